// File: verification/rvviTraceStim.txt
// test ctl order insn pc cause gprMask csrW csrMask csrR irq | expFlags expInsn expPc
// expGprWb expCsr expIrqChange expNmiCause (ctl and flag bits as decoded in the testbench)
1 7 1 13 100 0 0 0 0 0 0 1 13 100 0 0 0 0
1 7 1 13 100 0 0 0 0 0 0 0 13 100 0 0 0 0
1 7 2 100093 104 0 0 0 0 0 0 1 100093 104 0 0 0 0
1 7 3 200113 108 0 0 0 0 0 0 1 200113 108 0 0 0 0
1 6 4 0 0 0 0 0 0 0 0 0 200113 108 0 0 0 0
2 1f 4 13 200 30 0 0 0 0 0 183 13 200 0 0 0 0
2 6 4 0 0 0 0 0 0 0 0 82 13 200 0 0 0 0
2 1f 5 13 204 2 0 0 0 0 0 101 13 204 0 0 0 0
2 1f 6 13 208 5 0 0 0 0 0 1 13 208 0 0 0 0
3 7 7 93 20c 0 7 0 0 0 0 1 93 20c 6 0 0 0
3 7 8 113 210 0 80000401 0 0 0 0 1 113 210 80000400 0 0 0
4 6 8 0 0 0 0 12345678 ffff abcdef00 0 200 113 210 80000400 abcd5678 0 0
4 6 8 0 0 0 0 12345678 ffff abcdef00 0 200 113 210 80000400 abcd5678 0 0
4 7 9 13 214 0 0 12345678 ffff abcdef00 0 1 13 214 0 abcd5678 0 0
5 1606 9 0 0 0 0 12345678 ffff abcdef00 0 c 13 214 0 abcd5678 0 0
5 1667 a 13 218 4000000 0 12345678 ffff abcdef00 0 75 13 218 0 abcd5678 0 400
5 67 b 13 21c 4010000 0 12345678 ffff abcdef00 0 59 13 21c 0 abcd5678 0 401
5 7 c 13 220 0 0 12345678 ffff abcdef00 0 21 13 220 0 abcd5678 0 401
6 6 c 0 0 0 0 12345678 ffff abcdef00 80 0 13 220 0 abcd5678 80 401
6 6 c 0 0 0 0 12345678 ffff abcdef00 80 0 13 220 0 abcd5678 0 401
6 6 c 0 0 0 0 12345678 ffff abcdef00 a0 0 13 220 0 abcd5678 0 401
6 6 c 0 0 0 0 12345678 ffff abcdef00 20 0 13 220 0 abcd5678 80 401
6 6 c 0 0 0 0 12345678 ffff abcdef00 20 0 13 220 0 abcd5678 0 401

// File: rvviTraceAdapter.f
rtl/rvviTracePkg.sv
rtl/retireControl.sv
rtl/trapEventTracker.sv
rtl/csrMerge.sv
rtl/gprWriteback.sv
rtl/irqEdgeDetect.sv
rtl/rvviTraceAdapter.sv
verification/rvviTraceAdapter_assert.sv
verification/rvviTraceAdapterTb.sv

// File: runSim.sh
#!/bin/sh
# Build and run the trace adapter testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f rvviTraceAdapter.f \
   --top-module rvviTraceAdapterTb -o simv
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

out=$(./obj_dir/simv)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if echo "$out" | grep -qx "Test OK"; then
   exit 0
fi
exit 1

// File: verification/rvviTraceAdapterTb.sv
// Testbench for the trace adapter; replays rows of the stimulus file and checks the registered trace
module rvviTraceAdapterTb;

   localparam int ROWS = 23;
   localparam int COLS = 18;
   localparam int NUM_CSR = rvviTracePkg::NUM_CSR_DEFAULT;
   localparam int CSR_SLOT = 4;
   // Twice the rows plus margin
   localparam int TIMEOUT_CYCLES = 2 * ROWS + 20;

   logic                                           rvvi;
   logic                                           rstN_i;
   logic                                           rvfiValid_i;
   rvviTracePkg::orderT                            rvfiOrder_i;
   rvviTracePkg::xlenT                             rvfiInsn_i;
   rvviTracePkg::xlenT                             rvfiPcRdata_i;
   rvviTracePkg::xlenT                             rvfiPcWdata_i;
   rvviTracePkg::modeT                             rvfiMode_i;
   logic                                           rvfiTrap_i;
   logic                                           rvfiTrapException_i;
   rvviTracePkg::causeT                            rvfiTrapCause_i;
   logic                                           rvfiIntr_i;
   logic                                           rvfiIntrInterrupt_i;
   rvviTracePkg::causeT                            rvfiIntrCause_i;
   logic [1:0]                                     rvfiNmip_i;
   logic [2:0]                                     rvfiDbg_i;
   logic                                           rvfiDbgMode_i;
   rvviTracePkg::gprMaskT                          rvfiGprWmask_i;
   rvviTracePkg::xlenT [rvviTracePkg::NUM_GPR-1:0] rvfiGprWdata_i;
   rvviTracePkg::xlenT [NUM_CSR-1:0]               csrWdata_i;
   rvviTracePkg::xlenT [NUM_CSR-1:0]               csrRdata_i;
   rvviTracePkg::xlenT [NUM_CSR-1:0]               csrWmask_i;
   logic [31:0]                                    irq_i;
   logic                                           traceValid_o;
   rvviTracePkg::xlenT                             traceInsn_o;
   rvviTracePkg::xlenT                             tracePcRdata_o;
   rvviTracePkg::xlenT                             tracePcWdata_o;
   rvviTracePkg::modeT                             traceMode_o;
   logic                                           traceTrap_o;
   rvviTracePkg::gprMaskT                          gprWb_o;
   rvviTracePkg::xlenT [rvviTracePkg::NUM_GPR-1:0] gprData_o;
   rvviTracePkg::xlenT [NUM_CSR-1:0]               csrValue_o;
   logic [NUM_CSR-1:0]                             csrWb_o;
   logic                                           haltReq_o;
   logic                                           haltReqPush_o;
   logic                                           nmi_o;
   logic                                           nmiPush_o;
   rvviTracePkg::causeT                            nmiCause_o;
   logic                                           nmiCausePush_o;
   logic                                           iBusFault_o;
   logic                                           iBusFaultPush_o;
   logic [31:0]                                    irqLevel_o;
   logic [31:0]                                    irqChange_o;

   logic [31:0] stim [0:ROWS*COLS-1];
   int errors = 0;
   int checks = 0;
   int testErrors = 0;
   int testChecks = 0;
   int cycles = 0;
   // Tracked line levels, rebuilt from the expected change pulses
   rvviTracePkg::xlenT irqLevelExp = '0;
   string testNames [6] = '{"retirement", "fetch-fault filter", "register writeback",
                            "CSR merge", "halt request and NMI", "interrupt lines"};

   rvviTraceAdapter #(.NUM_CSR(NUM_CSR), .NUM_IRQ(32)) DUT (.*);

   initial rvvi = 1'b0;
   always #5 rvvi = ~rvvi;

   always @(posedge rvvi) begin
      cycles++;
      if (cycles >= TIMEOUT_CYCLES) begin
         $display("Timeout after %0d cycles, the stimulus did not finish", cycles);
         $display("Test FAILED");
         $finish;
      end
   end

   function automatic logic [31:0] col(input int r, input int c);
      return stim[r*COLS+c];
   endfunction

   //////////////////////////////////////////////////////////////////////
   // Compare tasks
   //////////////////////////////////////////////////////////////////////
   task automatic reportMismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] got);
      checks++;
      testChecks++;
      if (got !== exp) begin
         errors++;
         testErrors++;
         $display("FAILED at %0t: %s expected %0h got %0h", $time, name, exp, got);
      end
   endtask

   task automatic checkBit(input string name, input logic got, input logic exp);
      reportMismatch(name, 32'(exp), 32'(got));
   endtask

   task automatic checkWord(input string name, input rvviTracePkg::xlenT got,
                            input rvviTracePkg::xlenT exp);
      reportMismatch(name, exp, got);
   endtask

   task automatic checkMask(input string name, input rvviTracePkg::gprMaskT got,
                            input rvviTracePkg::gprMaskT exp);
      reportMismatch(name, exp, got);
   endtask

   task automatic checkCause(input string name, input rvviTracePkg::causeT got,
                             input rvviTracePkg::causeT exp);
      reportMismatch(name, 32'(exp), 32'(got));
   endtask

   // Write data of register i carries the order and the register index
   function automatic rvviTracePkg::xlenT gprPattern(input logic [31:0] ord, input int i);
      logic [7:0] idx;
      idx = i[7:0];
      return {ord[15:0], 8'hA5, idx};
   endfunction

   //////////////////////////////////////////////////////////////////////
   // Row drive and check
   //////////////////////////////////////////////////////////////////////
   task automatic driveRow(input int r);
      logic [31:0] ctl;
      logic [31:0] cs;
      ctl = col(r, 1);
      cs = col(r, 5);
      rvfiValid_i = ctl[0];
      rvfiMode_i = ctl[2:1];
      rvfiTrap_i = ctl[3];
      rvfiTrapException_i = ctl[4];
      rvfiIntr_i = ctl[5];
      rvfiIntrInterrupt_i = ctl[6];
      rvfiNmip_i = ctl[8:7];
      rvfiDbg_i = ctl[11:9];
      rvfiDbgMode_i = ctl[12];
      rvfiOrder_i = rvviTracePkg::orderT'(col(r, 2));
      rvfiInsn_i = col(r, 3);
      rvfiPcRdata_i = col(r, 4);
      rvfiPcWdata_i = col(r, 4) + 32'd4;
      rvfiTrapCause_i = cs[10:0];
      rvfiIntrCause_i = cs[26:16];
      rvfiGprWmask_i = col(r, 6);
      for (int i = 0; i < rvviTracePkg::NUM_GPR; i++) begin
         rvfiGprWdata_i[i] = gprPattern(col(r, 2), i);
      end
      csrWdata_i = '0;
      csrWmask_i = '0;
      csrRdata_i = '0;
      csrWdata_i[CSR_SLOT] = col(r, 7);
      csrWmask_i[CSR_SLOT] = col(r, 8);
      csrRdata_i[CSR_SLOT] = col(r, 9);
      irq_i = col(r, 10);
   endtask

   task automatic checkRow(input int r);
      logic [31:0] f;
      rvviTracePkg::gprMaskT expMask;
      f = col(r, 11);
      expMask = col(r, 14);
      irqLevelExp = irqLevelExp ^ col(r, 16);
      checkBit("traceValid_o", traceValid_o, f[0]);
      checkBit("traceTrap_o", traceTrap_o, f[1]);
      checkBit("haltReq_o", haltReq_o, f[2]);
      checkBit("haltReqPush_o", haltReqPush_o, f[3]);
      checkBit("nmi_o", nmi_o, f[4]);
      checkBit("nmiPush_o", nmiPush_o, f[5]);
      checkBit("nmiCausePush_o", nmiCausePush_o, f[6]);
      checkBit("iBusFault_o", iBusFault_o, f[7]);
      checkBit("iBusFaultPush_o", iBusFaultPush_o, f[8]);
      checkBit("csrWb_o", csrWb_o[CSR_SLOT], f[9]);
      checkWord("traceInsn_o", traceInsn_o, col(r, 12));
      checkWord("tracePcRdata_o", tracePcRdata_o, col(r, 13));
      checkWord("tracePcWdata_o", tracePcWdata_o, col(r, 13) + 32'd4);
      checkWord("traceMode_o", rvviTracePkg::xlenT'(traceMode_o), 32'd3);
      checkMask("gprWb_o", gprWb_o, expMask);
      checkWord($sformatf("csrValue_o[%03h]", rvviTracePkg::CSR_SLOT_ADDR[CSR_SLOT]),
                csrValue_o[CSR_SLOT], col(r, 15));
      checkWord("irqChange_o", irqChange_o, col(r, 16));
      checkWord("irqLevel_o", irqLevel_o, irqLevelExp);
      checkCause("nmiCause_o", nmiCause_o, rvviTracePkg::causeT'(col(r, 17)));
      // Data lanes follow the retirement just traced
      if (f[0]) begin
         for (int i = 0; i < rvviTracePkg::NUM_GPR; i++) begin
            checkWord($sformatf("gprData_o[%0d]", i), gprData_o[i],
                      expMask[i] ? gprPattern(col(r, 2), i) : '0);
         end
      end
   endtask

   initial begin
      rstN_i = 1'b0;
      $readmemh("verification/rvviTraceStim.txt", stim);
      if ($isunknown(stim[ROWS*COLS-1])) begin
         $display("The stimulus file could not be read completely");
         errors++;
      end
      driveRow(0);
      rvfiValid_i = 1'b0;
      irq_i = '0;
      csrWdata_i = '0;
      csrWmask_i = '0;
      csrRdata_i = '0;
      rvfiDbgMode_i = 1'b0;
      repeat (10) @(negedge rvvi);
      rstN_i = 1'b1;
      for (int r = 0; r < ROWS; r++) begin
         driveRow(r);
         @(negedge rvvi);
         checkRow(r);
         if (r == ROWS - 1 || col(r + 1, 0) != col(r, 0)) begin
            $display("test %0d %s: %s, %0d checks", col(r, 0), testNames[col(r, 0) - 1],
                     (testErrors == 0) ? "passed" : "failed", testChecks);
            testErrors = 0;
            testChecks = 0;
         end
      end
      $display("%0d checks, %0d errors", checks, errors);
      if (errors == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

endmodule

// File: verification/rvviTraceAdapter_assert.sv
// Concurrent checks on strobe, pulse and reset rules, bound into the trace adapter top level
module rvviTraceAdapterAssert #(
   parameter int NUM_CSR = rvviTracePkg::NUM_CSR_DEFAULT
) (
   input logic                                         rvvi,
   input logic                                         rstN_i,
   input rvviTracePkg::orderT                          rvfiOrder_i,
   input logic                                         traceValid_o,
   input logic                                         haltReq_o,
   input logic                                         haltReqPush_o,
   input logic                                         nmi_o,
   input logic                                         nmiPush_o,
   input logic                                         iBusFault_o,
   input logic                                         iBusFaultPush_o,
   input logic [NUM_CSR-1:0]                           csrWb_o
);

   // Back-to-back trace pulses need two distinct orders
   traceValidOrder: assert property (@(posedge rvvi) disable iff (!rstN_i)
      traceValid_o && $past(traceValid_o) |-> $past(rvfiOrder_i) != $past(rvfiOrder_i, 2))
      else $error("traceValid_o high twice for one order");

   haltPushOne: assert property (@(posedge rvvi) disable iff (!rstN_i)
      haltReqPush_o |=> !haltReqPush_o) else $error("haltReqPush_o longer than one cycle");

   nmiPushOne: assert property (@(posedge rvvi) disable iff (!rstN_i)
      nmiPush_o |=> !nmiPush_o) else $error("nmiPush_o longer than one cycle");

   faultPushOne: assert property (@(posedge rvvi) disable iff (!rstN_i)
      iBusFaultPush_o |=> !iBusFaultPush_o) else $error("iBusFaultPush_o longer than one cycle");

   resetQuiet: assert property (@(posedge rvvi) $rose(rstN_i) |->
      !traceValid_o && !haltReq_o && !nmi_o && !iBusFault_o && (csrWb_o == '0))
      else $error("outputs not cleared after reset");

endmodule

bind rvviTraceAdapter rvviTraceAdapterAssert #(.NUM_CSR(NUM_CSR)) uAssert (.*);

// File: rtl/rvviTraceAdapter.sv
// Top level of the retirement trace adapter; instance it beside the core and feed it the RVFI report
module rvviTraceAdapter #(
   parameter int NUM_CSR = rvviTracePkg::NUM_CSR_DEFAULT,
   parameter int NUM_IRQ = 32
) (
   input  logic                                            rvvi,
   input  logic                                            rstN_i,
   // Retirement report
   input  logic                                            rvfiValid_i,
   input  rvviTracePkg::orderT                             rvfiOrder_i,
   input  rvviTracePkg::xlenT                              rvfiInsn_i,
   input  rvviTracePkg::xlenT                              rvfiPcRdata_i,
   input  rvviTracePkg::xlenT                              rvfiPcWdata_i,
   input  rvviTracePkg::modeT                              rvfiMode_i,
   input  logic                                            rvfiTrap_i,
   input  logic                                            rvfiTrapException_i,
   input  rvviTracePkg::causeT                             rvfiTrapCause_i,
   input  logic                                            rvfiIntr_i,
   input  logic                                            rvfiIntrInterrupt_i,
   input  rvviTracePkg::causeT                             rvfiIntrCause_i,
   input  logic [1:0]                                      rvfiNmip_i,
   input  logic [2:0]                                      rvfiDbg_i,
   input  logic                                            rvfiDbgMode_i,
   input  rvviTracePkg::gprMaskT                           rvfiGprWmask_i,
   input  rvviTracePkg::xlenT [rvviTracePkg::NUM_GPR-1:0]  rvfiGprWdata_i,
   input  rvviTracePkg::xlenT [NUM_CSR-1:0]                csrWdata_i,
   input  rvviTracePkg::xlenT [NUM_CSR-1:0]                csrRdata_i,
   input  rvviTracePkg::xlenT [NUM_CSR-1:0]                csrWmask_i,
   input  logic [NUM_IRQ-1:0]                              irq_i,
   // Instruction trace
   output logic                                            traceValid_o,
   output rvviTracePkg::xlenT                              traceInsn_o,
   output rvviTracePkg::xlenT                              tracePcRdata_o,
   output rvviTracePkg::xlenT                              tracePcWdata_o,
   output rvviTracePkg::modeT                              traceMode_o,
   output logic                                            traceTrap_o,
   output rvviTracePkg::gprMaskT                           gprWb_o,
   output rvviTracePkg::xlenT [rvviTracePkg::NUM_GPR-1:0]  gprData_o,
   output rvviTracePkg::xlenT [NUM_CSR-1:0]                csrValue_o,
   output logic [NUM_CSR-1:0]                              csrWb_o,
   // Level nets with change pulses
   output logic                                            haltReq_o,
   output logic                                            haltReqPush_o,
   output logic                                            nmi_o,
   output logic                                            nmiPush_o,
   output rvviTracePkg::causeT                             nmiCause_o,
   output logic                                            nmiCausePush_o,
   output logic                                            iBusFault_o,
   output logic                                            iBusFaultPush_o,
   output logic [NUM_IRQ-1:0]                              irqLevel_o,
   output logic [NUM_IRQ-1:0]                              irqChange_o
);

   // Single-cycle strobe for each newly retired instruction
   logic retire;

   retireControl uRetireControl (
      .rvvi           (rvvi),
      .rstN_i         (rstN_i),
      .rvfiValid_i    (rvfiValid_i),
      .rvfiOrder_i    (rvfiOrder_i),
      .rvfiInsn_i     (rvfiInsn_i),
      .rvfiPcRdata_i  (rvfiPcRdata_i),
      .rvfiPcWdata_i  (rvfiPcWdata_i),
      .rvfiMode_i     (rvfiMode_i),
      .rvfiDbg_i      (rvfiDbg_i),
      .rvfiDbgMode_i  (rvfiDbgMode_i),
      .retire_o       (retire),
      .traceValid_o   (traceValid_o),
      .traceInsn_o    (traceInsn_o),
      .tracePcRdata_o (tracePcRdata_o),
      .tracePcWdata_o (tracePcWdata_o),
      .traceMode_o    (traceMode_o),
      .haltReq_o      (haltReq_o),
      .haltReqPush_o  (haltReqPush_o)
   );

   trapEventTracker uTrapEventTracker (
      .rvvi                (rvvi),
      .rstN_i              (rstN_i),
      .retire_i            (retire),
      .rvfiTrap_i          (rvfiTrap_i),
      .rvfiTrapException_i (rvfiTrapException_i),
      .rvfiTrapCause_i     (rvfiTrapCause_i),
      .rvfiIntr_i          (rvfiIntr_i),
      .rvfiIntrInterrupt_i (rvfiIntrInterrupt_i),
      .rvfiIntrCause_i     (rvfiIntrCause_i),
      .rvfiNmip_i          (rvfiNmip_i),
      .traceTrap_o         (traceTrap_o),
      .nmi_o               (nmi_o),
      .nmiPush_o           (nmiPush_o),
      .nmiCause_o          (nmiCause_o),
      .nmiCausePush_o      (nmiCausePush_o),
      .iBusFault_o         (iBusFault_o),
      .iBusFaultPush_o     (iBusFaultPush_o)
   );

   csrMerge #(
      .NUM_CSR (NUM_CSR)
   ) uCsrMerge (
      .rvvi       (rvvi),
      .rstN_i     (rstN_i),
      .retire_i   (retire),
      .csrWdata_i (csrWdata_i),
      .csrRdata_i (csrRdata_i),
      .csrWmask_i (csrWmask_i),
      .csrValue_o (csrValue_o),
      .csrWb_o    (csrWb_o)
   );

   gprWriteback uGprWriteback (
      .rvvi           (rvvi),
      .rstN_i         (rstN_i),
      .retire_i       (retire),
      .rvfiGprWmask_i (rvfiGprWmask_i),
      .rvfiGprWdata_i (rvfiGprWdata_i),
      .gprWb_o        (gprWb_o),
      .gprData_o      (gprData_o)
   );

   irqEdgeDetect #(
      .NUM_IRQ (NUM_IRQ)
   ) uIrqEdgeDetect (
      .rvvi        (rvvi),
      .rstN_i      (rstN_i),
      .irq_i       (irq_i),
      .irqLevel_o  (irqLevel_o),
      .irqChange_o (irqChange_o)
   );

endmodule

// File: rtl/irqEdgeDetect.sv
// Registers the tracked interrupt lines and pulses a change bit for each line that toggles
module irqEdgeDetect #(
   parameter int NUM_IRQ = 32
) (
   input  logic               rvvi,
   input  logic               rstN_i,
   input  logic [NUM_IRQ-1:0] irq_i,
   output logic [NUM_IRQ-1:0] irqLevel_o,
   output logic [NUM_IRQ-1:0] irqChange_o
);

   logic [NUM_IRQ-1:0] irqMasked;

   // Untracked lines stay at zero and so never pulse
   assign irqMasked = irq_i & rvviTracePkg::IRQ_TRACK_MASK[NUM_IRQ-1:0];

   always_ff @(posedge rvvi or negedge rstN_i) begin
      if (!rstN_i) begin
         irqLevel_o  <= '0;
         irqChange_o <= '0;
      end else begin
         irqLevel_o  <= irqMasked;
         irqChange_o <= irqMasked ^ irqLevel_o;
      end
   end

endmodule

// File: rtl/gprWriteback.sv
// Registers general-register writeback data and valid bits on each new retirement
module gprWriteback (
   input  logic                                           rvvi,
   input  logic                                           rstN_i,
   input  logic                                           retire_i,
   input  rvviTracePkg::gprMaskT                          rvfiGprWmask_i,
   input  rvviTracePkg::xlenT [rvviTracePkg::NUM_GPR-1:0] rvfiGprWdata_i,
   output rvviTracePkg::gprMaskT                          gprWb_o,
   output rvviTracePkg::xlenT [rvviTracePkg::NUM_GPR-1:0] gprData_o
);

   rvviTracePkg::gprMaskT gprWbNext;
   rvviTracePkg::xlenT [rvviTracePkg::NUM_GPR-1:0] gprDataNext;

   // x0 is never written
   assign gprWbNext = rvfiGprWmask_i & ~rvviTracePkg::gprMaskT'(1);

   // Unwritten lanes read as zero
   always_comb begin
      for (int i = 0; i < rvviTracePkg::NUM_GPR; i++) begin
         gprDataNext[i] = gprWbNext[i] ? rvfiGprWdata_i[i] : '0;
      end
   end

   always_ff @(posedge rvvi or negedge rstN_i) begin
      if (!rstN_i) begin
         gprWb_o   <= '0;
         gprData_o <= '0;
      end else if (retire_i) begin
         gprWb_o   <= gprWbNext;
         gprData_o <= gprDataNext;
      end
   end

endmodule

// File: rtl/csrMerge.sv
// Merges masked CSR write data with read data per slot and flags slots whose value changed
module csrMerge #(
   parameter int NUM_CSR = 8
) (
   input  logic                             rvvi,
   input  logic                             rstN_i,
   input  logic                             retire_i,
   input  rvviTracePkg::xlenT [NUM_CSR-1:0] csrWdata_i,
   input  rvviTracePkg::xlenT [NUM_CSR-1:0] csrRdata_i,
   input  rvviTracePkg::xlenT [NUM_CSR-1:0] csrWmask_i,
   output rvviTracePkg::xlenT [NUM_CSR-1:0] csrValue_o,
   output logic [NUM_CSR-1:0]               csrWb_o
);

   rvviTracePkg::xlenT [NUM_CSR-1:0] merged;
   logic [NUM_CSR-1:0] csrWbNext;

   // Written bits from wdata, untouched bits from rdata
   always_comb begin
      for (int i = 0; i < NUM_CSR; i++) begin
         merged[i] = (csrWdata_i[i] & csrWmask_i[i]) | (csrRdata_i[i] & ~csrWmask_i[i]);
      end
   end

   // A fresh change wins over the clear from a retirement
   always_comb begin
      for (int i = 0; i < NUM_CSR; i++) begin
         if (merged[i] != csrValue_o[i]) begin
            csrWbNext[i] = 1'b1;
         end else if (retire_i) begin
            csrWbNext[i] = 1'b0;
         end else begin
            csrWbNext[i] = csrWb_o[i];
         end
      end
   end

   always_ff @(posedge rvvi or negedge rstN_i) begin
      if (!rstN_i) begin
         csrValue_o <= '0;
         csrWb_o    <= '0;
      end else begin
         csrValue_o <= merged;
         csrWb_o    <= csrWbNext;
      end
   end

endmodule

// File: rtl/trapEventTracker.sv
// Derives the fetch-fault trap and the NMI and fetch-fault nets with their change pulses on retirement
module trapEventTracker (
   input  logic                rvvi,
   input  logic                rstN_i,
   input  logic                retire_i,
   input  logic                rvfiTrap_i,
   input  logic                rvfiTrapException_i,
   input  rvviTracePkg::causeT rvfiTrapCause_i,
   input  logic                rvfiIntr_i,
   input  logic                rvfiIntrInterrupt_i,
   input  rvviTracePkg::causeT rvfiIntrCause_i,
   input  logic [1:0]          rvfiNmip_i,
   output logic                traceTrap_o,
   output logic                nmi_o,
   output logic                nmiPush_o,
   output rvviTracePkg::causeT nmiCause_o,
   output logic                nmiCausePush_o,
   output logic                iBusFault_o,
   output logic                iBusFaultPush_o
);

   logic nmiCond;
   logic fetchFault;
   logic fetchFaultQ;

   // Load or store bus error, either as a reported interrupt or as pending
   assign nmiCond = (rvfiIntr_i && rvfiIntrInterrupt_i &&
                     ((rvfiIntrCause_i == rvviTracePkg::NMI_LOAD_CAUSE) ||
                      (rvfiIntrCause_i == rvviTracePkg::NMI_STORE_CAUSE))) ||
                    (|rvfiNmip_i);

   assign fetchFault = rvfiTrap_i && rvfiTrapException_i &&
                       (rvfiTrapCause_i == rvviTracePkg::IBUS_FAULT_CAUSE);

   // Trace trap flag and fault net carry the same level
   assign traceTrap_o = fetchFaultQ;
   assign iBusFault_o = fetchFaultQ;

   always_ff @(posedge rvvi or negedge rstN_i) begin
      if (!rstN_i) begin
         nmi_o           <= 1'b0;
         nmiPush_o       <= 1'b0;
         nmiCause_o      <= '0;
         nmiCausePush_o  <= 1'b0;
         fetchFaultQ     <= 1'b0;
         iBusFaultPush_o <= 1'b0;
      end else if (retire_i) begin
         nmi_o     <= nmiCond;
         nmiPush_o <= nmiCond != nmi_o;
         if (nmiCond) begin
            nmiCause_o     <= rvfiIntrCause_i;
            nmiCausePush_o <= rvfiIntrCause_i != nmiCause_o;
         end else begin
            nmiCausePush_o <= 1'b0;
         end
         fetchFaultQ     <= fetchFault;
         iBusFaultPush_o <= fetchFault != fetchFaultQ;
      end else begin
         // Levels hold between retirements
         nmiPush_o       <= 1'b0;
         nmiCausePush_o  <= 1'b0;
         iBusFaultPush_o <= 1'b0;
      end
   end

endmodule

// File: rtl/retireControl.sv
// Detects new retirements, registers the instruction fields and tracks the debug halt request
module retireControl (
   input  logic                rvvi,
   input  logic                rstN_i,
   input  logic                rvfiValid_i,
   input  rvviTracePkg::orderT rvfiOrder_i,
   input  rvviTracePkg::xlenT  rvfiInsn_i,
   input  rvviTracePkg::xlenT  rvfiPcRdata_i,
   input  rvviTracePkg::xlenT  rvfiPcWdata_i,
   input  rvviTracePkg::modeT  rvfiMode_i,
   input  logic [2:0]          rvfiDbg_i,
   input  logic                rvfiDbgMode_i,
   output logic                retire_o,
   output logic                traceValid_o,
   output rvviTracePkg::xlenT  traceInsn_o,
   output rvviTracePkg::xlenT  tracePcRdata_o,
   output rvviTracePkg::xlenT  tracePcWdata_o,
   output rvviTracePkg::modeT  traceMode_o,
   output logic                haltReq_o,
   output logic                haltReqPush_o
);

   rvviTracePkg::orderT lastOrder;
   logic haltCond;
   logic haltReqNext;

   // A repeated order is the same retirement seen again
   assign retire_o = rvfiValid_i && (rvfiOrder_i != lastOrder);

   //////////////////////////////////////////////////////////////////////
   // Instruction trace
   //////////////////////////////////////////////////////////////////////
   always_ff @(posedge rvvi or negedge rstN_i) begin
      if (!rstN_i) begin
         lastOrder      <= '0;
         traceValid_o   <= 1'b0;
         traceInsn_o    <= '0;
         tracePcRdata_o <= '0;
         tracePcWdata_o <= '0;
         traceMode_o    <= '0;
      end else begin
         traceValid_o <= retire_o;
         if (retire_o) begin
            lastOrder      <= rvfiOrder_i;
            traceInsn_o    <= rvfiInsn_i;
            tracePcRdata_o <= rvfiPcRdata_i;
            tracePcWdata_o <= rvfiPcWdata_i;
            traceMode_o    <= rvfiMode_i;
         end
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Halt request
   //////////////////////////////////////////////////////////////////////
   assign haltCond = (rvfiDbg_i == rvviTracePkg::DBG_CAUSE_HALTREQ) && rvfiDbgMode_i;

   // Sets on the condition alone, clears only on a retirement without it
   always_comb begin
      haltReqNext = haltReq_o;
      if (haltCond) begin
         haltReqNext = 1'b1;
      end else if (retire_o) begin
         haltReqNext = 1'b0;
      end
   end

   always_ff @(posedge rvvi or negedge rstN_i) begin
      if (!rstN_i) begin
         haltReq_o     <= 1'b0;
         haltReqPush_o <= 1'b0;
      end else begin
         haltReq_o     <= haltReqNext;
         haltReqPush_o <= haltReqNext != haltReq_o;
      end
   end

endmodule

// File: rtl/rvviTracePkg.sv
// Shared widths, cause codes, CSR slot table and IRQ mask for the RVVI trace adapter and its testbench
package rvviTracePkg;

   //////////////////////////////////////////////////////////////////////
   // Trace widths
   //////////////////////////////////////////////////////////////////////
   parameter int XLEN = 32;
   typedef logic [XLEN-1:0] xlenT;

   // Retirement order number as reported by RVFI
   typedef logic [63:0] orderT;

   parameter int NUM_GPR = 32;
   typedef logic [NUM_GPR-1:0] gprMaskT;

   typedef logic [10:0] causeT;
   typedef logic [1:0] modeT;

   //////////////////////////////////////////////////////////////////////
   // Cause codes
   //////////////////////////////////////////////////////////////////////
   // Instruction fetch bus fault, the only trap passed to the trace
   parameter causeT IBUS_FAULT_CAUSE = 11'd48;
   // Data bus errors reported as NMI
   parameter causeT NMI_LOAD_CAUSE = 11'd1024;
   parameter causeT NMI_STORE_CAUSE = 11'd1025;
   // Debug cause for an external halt request
   parameter logic [2:0] DBG_CAUSE_HALTREQ = 3'd3;

   //////////////////////////////////////////////////////////////////////
   // Tracked CSRs and interrupt lines
   //////////////////////////////////////////////////////////////////////
   parameter int NUM_CSR_DEFAULT = 8;

   // Slot order: mstatus, misa, mie, mtvec, mscratch, mepc, mcause, mtval
   parameter logic [11:0] CSR_SLOT_ADDR [NUM_CSR_DEFAULT] = '{
      12'h300, 12'h301, 12'h304, 12'h305,
      12'h340, 12'h341, 12'h342, 12'h343
   };

   // Software, timer and external IRQs plus the 16 local lines
   parameter logic [31:0] IRQ_TRACK_MASK = 32'hFFFF_0888;

endpackage
